/* src/distrib_config.svh */
/*
  Build-time sizing for the broadcast subsystem.
  Included by both packages and by any module that needs a default size.
*/

`ifndef DISTRIB_CONFIG_SVH
`define DISTRIB_CONFIG_SVH

//////////////////////////////////////////////////
// channel fan-out
//////////////////////////////////////////////////

// number of output channels fed from the one input
`define DISTRIB_NUM_CHANNELS 4

//////////////////////////////////////////////////
// payload
//////////////////////////////////////////////////

// tdata width in bits
`define DISTRIB_DATA_WIDTH 32

//////////////////////////////////////////////////
// per-channel buffering
//////////////////////////////////////////////////

// entries per channel FIFO
// must stay a power of two so the pointers wrap on their own
`define DISTRIB_FIFO_DEPTH 8

`endif

/* src/stream_pkg.sv */
/*
  Payload types carried on the AXI-stream links.
  Modules name these by scope in their ports and import the package in the body.
*/

package stream_pkg;

  `include "distrib_config.svh"

  //////////////////////////////////////////////////
  // stream payload
  //////////////////////////////////////////////////

  // one tdata word
  typedef logic [`DISTRIB_DATA_WIDTH-1:0] data_t;

  // one word per output channel
  // element n goes out on channel n
  typedef data_t [`DISTRIB_NUM_CHANNELS-1:0] data_array_t;

endpackage

/* src/distrib_pkg.sv */
/*
  Bookkeeping types for the distributor and the channel FIFOs.
  Channel masks hold one bit per output, FIFO counts hold occupancy.
*/

package distrib_pkg;

  `include "distrib_config.svh"

  //////////////////////////////////////////////////
  // per-channel flags
  //////////////////////////////////////////////////

  // bit n belongs to channel n
  // used for valid, ready and served flags
  typedef logic [`DISTRIB_NUM_CHANNELS-1:0] chan_mask_t;

  //////////////////////////////////////////////////
  // FIFO occupancy
  //////////////////////////////////////////////////

  // needs to hold 0 up to the full depth inclusive
  typedef logic [$clog2(`DISTRIB_FIFO_DEPTH+1)-1:0] fifo_count_t;

endpackage

/* src/axis_skid_buffer.sv */
/*
  Two-entry AXI-stream register slice for the input side.
  Main register drives the output, skid register catches a beat in flight
  when the output stalls, so the upstream ready comes straight from a flop.
*/
`timescale 1ns/100ps

module axis_skid_buffer #(
  parameter type payload_t = stream_pkg::data_t
) (
  input  logic     s_axis_clk,
  input  logic     arst_n,
  // upstream side
  input  logic     s_axis_tvalid,
  output logic     s_axis_tready,
  input  payload_t s_axis_tdata,
  // downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // skid entry
  logic     skid_valid;
  payload_t skid_data;

  // handshake terms
  logic in_fire;
  logic main_load;
  logic skid_valid_next;
  logic out_valid_next;

  //////////////////////////////////////////////////
  // next-state decode
  //////////////////////////////////////////////////

  assign in_fire   = s_axis_tvalid & s_axis_tready;
  // main register free or being drained this cycle
  assign main_load = ~out_valid | out_ready;

  // skid empties whenever main can take a beat
  // no input is accepted while skid is full
  assign skid_valid_next = main_load ? 1'b0 : (skid_valid | in_fire);
  assign out_valid_next  = main_load ? (skid_valid | in_fire) : 1'b1;

  //////////////////////////////////////////////////
  // control flops
  //////////////////////////////////////////////////

  always_ff @(posedge s_axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid     <= 1'b0;
      skid_valid    <= 1'b0;
      s_axis_tready <= 1'b0;
    end else begin
      out_valid     <= out_valid_next;
      skid_valid    <= skid_valid_next;
      // ready only while a slot will be free
      s_axis_tready <= ~skid_valid_next;
    end
  end

  //////////////////////////////////////////////////
  // payload registers
  //////////////////////////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    // skid beat has priority, it is older
    if (main_load) begin
      out_data <= skid_valid ? skid_data : s_axis_tdata;
    end
    // catch the in-flight beat on a stall
    if (in_fire && !main_load) begin
      skid_data <= s_axis_tdata;
    end
  end

  // stalled beat must not change under the consumer
  a_out_hold : assert property (@(posedge s_axis_clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

/* src/axis_distrib.sv */
/*
  Broadcast control for one shared beat.
  Offers the beat to every channel still owed it and releases it upstream
  once all channels have taken a copy. Data is wired past this block.
*/
`timescale 1ns/100ps

module axis_distrib (
  input  logic                   s_axis_clk,
  input  logic                   arst_n,
  // shared bus from the skid buffer
  input  logic                   bus_valid,
  output logic                   bus_ready,
  // per-channel handshake toward the FIFOs
  output distrib_pkg::chan_mask_t chan_valid,
  input  distrib_pkg::chan_mask_t chan_ready
);

  import distrib_pkg::*;

  // channels that already took the current beat
  chan_mask_t served_q;

  // acceptances in this cycle
  chan_mask_t chan_fire;

  // served after this cycle, if the beat stays
  chan_mask_t served_now;

  //////////////////////////////////////////////////
  // channel offer
  //////////////////////////////////////////////////

  // offer only to channels still owed the beat
  assign chan_valid = bus_valid ? ~served_q : '0;
  assign chan_fire  = chan_valid & chan_ready;
  assign served_now = served_q | chan_fire;

  //////////////////////////////////////////////////
  // release of the shared beat
  //////////////////////////////////////////////////

  // every channel served earlier or right now
  assign bus_ready = bus_valid & (&served_now);

  always_ff @(posedge s_axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      served_q <= '0;
    end else if (bus_ready) begin
      // beat leaves, next beat starts clean
      served_q <= '0;
    end else begin
      served_q <= served_now;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a channel that took the beat is not offered it again
  // until the beat is released
  a_no_reoffer : assert property (@(posedge s_axis_clk) disable iff (!arst_n)
    (!bus_ready && (|chan_fire)) |=> ((chan_valid & $past(chan_fire)) == '0));

  // full coverage always releases the beat in the same cycle
  // so the mask register never holds all ones
  a_full_mask_release : assert property (@(posedge s_axis_clk) disable iff (!arst_n)
    (&served_now) |-> bus_ready);

endmodule

/* src/axis_channel_fifo.sv */
/*
  Single-clock FIFO between the distributor and one output channel.
  Circular buffer with read and write pointers and an occupancy count.
  A written beat shows on the output after the write edge, no fall-through.
*/
`timescale 1ns/100ps
`include "distrib_config.svh"

module axis_channel_fifo #(
  parameter type payload_t = stream_pkg::data_t,
  parameter int  DEPTH     = `DISTRIB_FIFO_DEPTH
) (
  input  logic     s_axis_clk,
  input  logic     arst_n,
  // write side from the distributor
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // read side to the channel consumer
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  import distrib_pkg::*;

  // pointers wrap by themselves
  // DEPTH is a power of two
  localparam int PTR_W = $clog2(DEPTH);

  // storage
  payload_t mem [DEPTH];

  // control state
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_count_t      count;

  // handshake terms
  logic full;
  logic push;
  logic pop;

  //////////////////////////////////////////////////
  // status and handshake
  //////////////////////////////////////////////////

  assign full      = (count == fifo_count_t'(DEPTH));
  assign in_ready  = ~full;
  assign out_valid = (count != '0);

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // head of queue
  assign out_data = mem[rd_ptr];

  //////////////////////////////////////////////////
  // storage write
  //////////////////////////////////////////////////

  always_ff @(posedge s_axis_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  //////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge s_axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count as is
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // the push that fills the last slot closes the write side
  a_no_push_full : assert property (@(posedge s_axis_clk) disable iff (!arst_n)
    (push && !pop && count == fifo_count_t'(DEPTH - 1)) |=> !in_ready);

  // occupancy stays within the storage
  a_count_bound : assert property (@(posedge s_axis_clk) disable iff (!arst_n)
    count <= fifo_count_t'(DEPTH));

endmodule

/* src/axis_distrib_top.sv */
/*
  Broadcast subsystem top. One input stream goes through a skid buffer
  to the distributor, which copies every beat into one FIFO per channel.
*/
`timescale 1ns/100ps
`include "distrib_config.svh"

module axis_distrib_top (
  input  logic                     s_axis_clk,
  input  logic                     arst_n,
  // input stream
  input  logic                     s_axis_tvalid,
  output logic                     s_axis_tready,
  input  stream_pkg::data_t        s_axis_tdata,
  // output channels
  output distrib_pkg::chan_mask_t  m_axis_tvalid,
  input  distrib_pkg::chan_mask_t  m_axis_tready,
  output stream_pkg::data_array_t  m_axis_tdata
);

  import stream_pkg::*;
  import distrib_pkg::*;

  // shared bus after the skid buffer
  logic  bus_valid;
  logic  bus_ready;
  data_t bus_data;

  // per-channel handshake into the FIFOs
  chan_mask_t chan_valid;
  chan_mask_t chan_ready;

  //////////////////////////////////////////////////
  // input register slice
  //////////////////////////////////////////////////

  axis_skid_buffer #(
    .payload_t (data_t)
  ) u_skid (
    .s_axis_clk    (s_axis_clk),
    .arst_n        (arst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .out_valid     (bus_valid),
    .out_ready     (bus_ready),
    .out_data      (bus_data)
  );

  // broadcast control
  axis_distrib u_distrib (
    .s_axis_clk (s_axis_clk),
    .arst_n     (arst_n),
    .bus_valid  (bus_valid),
    .bus_ready  (bus_ready),
    .chan_valid (chan_valid),
    .chan_ready (chan_ready)
  );

  //////////////////////////////////////////////////
  // one FIFO per channel
  //////////////////////////////////////////////////

  // all FIFOs see the same bus data
  for (genvar ch = 0; ch < `DISTRIB_NUM_CHANNELS; ch++) begin : g_chan
    axis_channel_fifo #(
      .payload_t (data_t),
      .DEPTH     (`DISTRIB_FIFO_DEPTH)
    ) u_fifo (
      .s_axis_clk (s_axis_clk),
      .arst_n     (arst_n),
      .in_valid   (chan_valid[ch]),
      .in_ready   (chan_ready[ch]),
      .in_data    (bus_data),
      .out_valid  (m_axis_tvalid[ch]),
      .out_ready  (m_axis_tready[ch]),
      .out_data   (m_axis_tdata[ch])
    );
  end

endmodule

/* dv/tb_axis_distrib_top.sv */
/*
  Self-checking testbench for the broadcast subsystem.
  Sends an indexed word sequence and checks every channel against a reference
  function. Runs reset, latency, streaming, random back-pressure and stall tests.
*/
`timescale 1ns/100ps
`include "distrib_config.svh"

module tb_axis_distrib_top;

  import stream_pkg::*;
  import distrib_pkg::*;

  localparam int NUM_CH          = `DISTRIB_NUM_CHANNELS;
  localparam int DEPTH           = `DISTRIB_FIFO_DEPTH;
  localparam int CLK_PERIOD      = 8;
  localparam int STREAM_BEATS    = 64;
  localparam int RANDOM_BEATS    = 200;
  localparam int STALL_BEATS     = 40;
  localparam int STALL_CYCLES    = 100;
  localparam int PLANNED_BEATS   = 1 + STREAM_BEATS + RANDOM_BEATS + STALL_BEATS;
  localparam int WATCHDOG_CYCLES = 20 * PLANNED_BEATS + 2000;

  // output ready patterns
  localparam int READY_ALL    = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_HOLD0  = 2;

  logic        s_axis_clk = 1'b0;
  logic        arst_n;
  logic        s_axis_tvalid;
  logic        s_axis_tready;
  data_t       s_axis_tdata;
  chan_mask_t  m_axis_tvalid;
  chan_mask_t  m_axis_tready;
  data_array_t m_axis_tdata;

  // bookkeeping
  int seed = 5;
  int ready_mode = READY_ALL;
  int sent_count = 0;
  int rx_count [NUM_CH];
  int check_errors = 0;
  int main_errors = 0;
  int pass_count = 0;
  int fail_count = 0;

  axis_distrib_top dut (
    .s_axis_clk    (s_axis_clk),
    .arst_n        (arst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata)
  );

  always #(CLK_PERIOD / 2) s_axis_clk = ~s_axis_clk;

  //////////////////////////////////////////////////
  // reference and helpers
  //////////////////////////////////////////////////

  // word carried by beat idx, a fixed mix of the index
  function automatic data_t expected_word(input int idx);
    logic [31:0] mixed;
    mixed = idx * 32'h9E37_79B1;
    mixed = mixed ^ (mixed >> 15) ^ 32'hA5C3_0000;
    return data_t'(mixed);
  endfunction

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = check_errors + main_errors - errs_before;
    if (errs == 0) begin
      pass_count++;
      $display("test %s: ok", name);
    end else begin
      fail_count++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // starts and ends 1 ns after a rising edge
  // a beat not yet taken is left on the bus
  task automatic drive_input(input int beats, input int cycles, input bit rand_valid);
    int   done_beats;
    int   cyc;
    logic accepted;
    done_beats = 0;
    cyc = 0;
    while (done_beats < beats && cyc < cycles) begin
      if (!s_axis_tvalid) begin
        if (!rand_valid || ($random(seed) & 3) != 0) begin
          s_axis_tvalid = 1'b1;
          s_axis_tdata  = expected_word(sent_count);
        end
      end
      @(negedge s_axis_clk);
      accepted = s_axis_tvalid && s_axis_tready;
      @(posedge s_axis_clk);
      #1;
      if (accepted) begin
        sent_count++;
        done_beats++;
        s_axis_tvalid = 1'b0;
      end
      cyc++;
    end
  endtask

  // wait until every channel has delivered all sent beats
  task automatic wait_drain;
    bit busy;
    busy = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (rx_count[ch] != sent_count) busy = 1'b1;
      end
      if (busy) begin
        @(posedge s_axis_clk);
        #1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // output ready and checking
  //////////////////////////////////////////////////

  initial begin
    m_axis_tready = '1;
    forever begin
      @(posedge s_axis_clk);
      #1;
      case (ready_mode)
        READY_ALL:    m_axis_tready = '1;
        READY_RANDOM: m_axis_tready = chan_mask_t'($random(seed));
        default:      m_axis_tready = ~chan_mask_t'(1);
      endcase
    end
  end

  // mid-cycle sample, the transfer happens on the next rising edge
  always @(negedge s_axis_clk) begin
    if (arst_n) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (m_axis_tvalid[ch] && m_axis_tready[ch]) begin
          if (rx_count[ch] >= sent_count) begin
            check_errors++;
            $display("channel %0d delivered a beat that was never sent", ch);
          end else if (m_axis_tdata[ch] !== expected_word(rx_count[ch])) begin
            check_errors++;
            $display("mismatch at %0t: channel %0d beat %0d expected %h got %h", $time, ch,
                     rx_count[ch], expected_word(rx_count[ch]), m_axis_tdata[ch]);
          end
          rx_count[ch]++;
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the run was still going after %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int errs;
    int base;
    arst_n        = 1'b0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    for (int ch = 0; ch < NUM_CH; ch++) rx_count[ch] = 0;

    // reset state
    errs = 0;
    repeat (8) begin
      @(negedge s_axis_clk);
      if (m_axis_tvalid != '0 || s_axis_tready) begin
        main_errors++;
        $display("mismatch at %0t: outputs active during reset", $time);
      end
    end
    @(posedge s_axis_clk);
    #1;
    arst_n = 1'b1;
    @(posedge s_axis_clk);
    #1;
    if (!s_axis_tready || m_axis_tvalid != '0) begin
      main_errors++;
      $display("mismatch at %0t: tready %b tvalid %b after release", $time,
               s_axis_tready, m_axis_tvalid);
    end
    report_test("reset", errs);

    // skid register on the accept edge, FIFO on the next one
    errs = check_errors + main_errors;
    s_axis_tvalid = 1'b1;
    s_axis_tdata  = expected_word(sent_count);
    @(negedge s_axis_clk);
    if (!s_axis_tready) begin
      main_errors++;
      $display("input was not ready for the latency beat");
    end
    @(posedge s_axis_clk);
    #1;
    s_axis_tvalid = 1'b0;
    sent_count++;
    if (m_axis_tvalid != '0) begin
      main_errors++;
      $display("mismatch at %0t: tvalid %b one edge after acceptance", $time, m_axis_tvalid);
    end
    @(posedge s_axis_clk);
    #1;
    if (m_axis_tvalid != '1) begin
      main_errors++;
      $display("mismatch at %0t: tvalid %b two edges after acceptance", $time, m_axis_tvalid);
    end
    wait_drain;
    report_test("latency", errs);

    // back-to-back beats, all channels ready
    errs = check_errors + main_errors;
    drive_input(STREAM_BEATS, STREAM_BEATS * 20, 1'b0);
    wait_drain;
    report_test("streaming", errs);

    // random input valid and per-channel ready
    errs = check_errors + main_errors;
    base = sent_count;
    ready_mode = READY_RANDOM;
    drive_input(RANDOM_BEATS, RANDOM_BEATS * 20, 1'b1);
    wait_drain;
    ready_mode = READY_ALL;
    repeat (4) @(posedge s_axis_clk);
    #1;
    if (sent_count - base != RANDOM_BEATS) begin
      main_errors++;
      $display("mismatch at %0t: %0d beats sent, expected %0d", $time,
               sent_count - base, RANDOM_BEATS);
    end
    report_test("random back-pressure", errs);

    // channel 0 never ready, input kept full
    errs = check_errors + main_errors;
    base = sent_count;
    ready_mode = READY_HOLD0;
    @(posedge s_axis_clk);
    #1;
    drive_input(STALL_BEATS, STALL_CYCLES, 1'b0);
    for (int ch = 1; ch < NUM_CH; ch++) begin
      if (rx_count[ch] - base != DEPTH + 1) begin
        main_errors++;
        $display("mismatch at %0t: channel %0d got %0d beats in the stall, expected %0d",
                 $time, ch, rx_count[ch] - base, DEPTH + 1);
      end
    end
    // channel 0 holds the first stalled beat at its head
    if (!m_axis_tvalid[0] || m_axis_tdata[0] !== expected_word(base) || s_axis_tready) begin
      main_errors++;
      $display("mismatch at %0t: channel 0 tvalid %b data %h expected %h, tready %b",
               $time, m_axis_tvalid[0], m_axis_tdata[0], expected_word(base),
               s_axis_tready);
    end
    ready_mode = READY_ALL;
    drive_input(STALL_BEATS - (sent_count - base), STALL_BEATS * 20, 1'b0);
    wait_drain;
    report_test("stall", errs);

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && check_errors == 0 && main_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+src
src/stream_pkg.sv
src/distrib_pkg.sv
src/axis_skid_buffer.sv
src/axis_distrib.sv
src/axis_channel_fifo.sv
src/axis_distrib_top.sv
dv/tb_axis_distrib_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the broadcast subsystem testbench with Verilator.
# Exit status is 0 only when the log holds no fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_axis_distrib_top \
  -f sources.f -o sim_tb \
  && ./obj_dir/sim_tb > "$LOG" 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -qF "*** FAILED ***" "$LOG" \
  && { echo "result: fail"; exit 1; } \
  || { echo "result: pass"; exit 0; }
